// ==== sources.f ====
+incdir+logic
logic/fcpu_pkg.sv
logic/register_file.sv
logic/reorder_buffer.sv
logic/rename_csr.sv
logic/rename_core.sv
test/rename_core_tb.sv

// ==== Bender.yml ====
package:
  name: rename_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/fcpu_pkg.sv
      - logic/register_file.sv
      - logic/reorder_buffer.sv
      - logic/rename_csr.sv
      - logic/rename_core.sv
      - target: test
        files:
          - test/rename_core_tb.sv

// ==== test/rename_core_tb.sv ====
`include "fcpu_defines.svh"

module rename_core_tb;

   localparam logic [3:0] OP_DISPATCH = 4'd0;
   localparam logic [3:0] OP_WB       = 4'd1;
   localparam logic [3:0] OP_IDLE     = 4'd2;
   localparam logic [3:0] OP_MISS     = 4'd3;
   localparam logic [3:0] OP_WRITE    = 4'd4;
   localparam logic [3:0] OP_READ     = 4'd5;
   localparam logic [3:0] OP_CHECK    = 4'd6;
   localparam int WAIT_LIMIT = 20;

   // For a dispatch, expected holds {ready, tag}; for a check, the whole operand
   typedef struct packed {
      logic [3:0]  op;
      logic [31:0] arg;
      logic [31:0] data;
      logic [32:0] expected;
   } step_t;

   logic                   clk;
   logic                   nrst;
   logic                   branch_miss;
   logic                   dispatch_valid;
   logic                   dispatch_ready;
   fcpu_pkg::dispatch_t    dispatch;
   logic [`FCPU_TAG_W-1:0] dispatch_tag;
   fcpu_pkg::operand_t     src_a;
   fcpu_pkg::operand_t     src_b;
   fcpu_pkg::writeback_t   wb;
   logic                   awvalid;
   logic                   awready;
   logic [3:0]             awaddr;
   logic                   wvalid;
   logic                   wready;
   logic [31:0]            wdata;
   logic [3:0]             wstrb;
   logic                   bvalid;
   logic                   bready;
   logic [1:0]             bresp;
   logic                   arvalid;
   logic                   arready;
   logic [3:0]             araddr;
   logic                   rvalid;
   logic                   rready;
   logic [31:0]            rdata;
   logic [1:0]             rresp;

   step_t       steps[$];
   string       step_names[$];
   logic [31:0] pool [0:7];
   int          errors;
   int          timeouts;

   rename_core rename_core_i (
      .clk, .nrst, .branch_miss, .dispatch_valid, .dispatch_ready, .dispatch,
      .dispatch_tag, .src_a, .src_b, .wb,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp, .arvalid, .arready, .araddr,
      .rvalid, .rready, .rdata, .rresp
   );

   always #10 clk = ~clk;

   function automatic logic [32:0] ready_operand(input logic [31:0] value);
      return {1'b1, value};
   endfunction

   // A pending operand carries only the producer tag in its low bits
   function automatic logic [32:0] pending_operand(input int tag);
      return {1'b0, 29'd0, 3'(tag)};
   endfunction

   function automatic logic [32:0] grant(input int tag, input logic rdy);
      return {rdy, 29'd0, 3'(tag)};
   endfunction

   task automatic add_step(input string name, input logic [3:0] op, input logic [31:0] arg,
                           input logic [31:0] data, input logic [32:0] expected);
      step_t s;
      s.op       = op;
      s.arg      = arg;
      s.data     = data;
      s.expected = expected;
      steps.push_back(s);
      step_names.push_back(name);
   endtask

   task automatic build_table();
      add_step("reset r1 operand", OP_CHECK, 1, 0, ready_operand(0));
      add_step("reset status", OP_READ, 32'h0, 0, 33'h0);
      add_step("reset commit count", OP_READ, 32'h4, 0, 33'h0);
      add_step("dispatch r1", OP_DISPATCH, 1, 0, grant(0, 1'b1));
      add_step("dispatch r2", OP_DISPATCH, 2, 0, grant(1, 1'b1));
      add_step("r1 pending", OP_CHECK, 1, 0, pending_operand(0));
      add_step("r2 pending", OP_CHECK, 2, 0, pending_operand(1));
      // Younger result first, so the head still blocks retirement
      add_step("writeback tag 1", OP_WB, 1, pool[1], 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("r2 waits for older", OP_CHECK, 2, 0, pending_operand(1));
      add_step("status two in flight", OP_READ, 32'h0, 0, 33'h2);
      add_step("writeback tag 0", OP_WB, 0, pool[0], 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("r1 committed", OP_CHECK, 1, 0, ready_operand(pool[0]));
      add_step("r2 committed", OP_CHECK, 2, 0, ready_operand(pool[1]));
      add_step("commit count two", OP_READ, 32'h4, 0, 33'h2);
      add_step("dispatch r3 older", OP_DISPATCH, 3, 0, grant(2, 1'b1));
      add_step("dispatch r3 younger", OP_DISPATCH, 3, 0, grant(3, 1'b1));
      add_step("r3 renamed twice", OP_CHECK, 3, 0, pending_operand(3));
      add_step("writeback tag 2", OP_WB, 2, pool[2], 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("r3 keeps younger tag", OP_CHECK, 3, 0, pending_operand(3));
      add_step("writeback tag 3", OP_WB, 3, pool[3], 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("r3 younger value", OP_CHECK, 3, 0, ready_operand(pool[3]));
      add_step("commit count four", OP_READ, 32'h4, 0, 33'h4);
      for (int k = 0; k < 8; k++) begin
         add_step($sformatf("fill r%0d", 4 + k), OP_DISPATCH, 4 + k, 0,
                  grant((4 + k) % 8, 1'b1));
      end
      add_step("dispatch refused when full", OP_DISPATCH, 12, 0, grant(4, 1'b0));
      add_step("r12 untouched", OP_CHECK, 12, 0, ready_operand(0));
      add_step("status full", OP_READ, 32'h0, 0, 33'h18);
      add_step("control flush", OP_WRITE, 32'h8, 1, 0);
      add_step("r11 ready after flush", OP_CHECK, 11, 0, ready_operand(0));
      add_step("r1 kept after flush", OP_CHECK, 1, 0, ready_operand(pool[0]));
      add_step("r3 kept after flush", OP_CHECK, 3, 0, ready_operand(pool[3]));
      add_step("status after flush", OP_READ, 32'h0, 0, 33'h0);
      add_step("dispatch r5 after flush", OP_DISPATCH, 5, 0, grant(0, 1'b1));
      add_step("r5 pending", OP_CHECK, 5, 0, pending_operand(0));
      add_step("branch miss", OP_MISS, 0, 0, 0);
      add_step("r5 ready after miss", OP_CHECK, 5, 0, ready_operand(0));
      add_step("status after miss", OP_READ, 32'h0, 0, 33'h0);
      add_step("dispatch r6 after miss", OP_DISPATCH, 6, 0, grant(0, 1'b1));
      add_step("writeback tag 0 again", OP_WB, 0, pool[4], 0);
      add_step("idle", OP_IDLE, 0, 0, 0);
      add_step("r6 committed", OP_CHECK, 6, 0, ready_operand(pool[4]));
      add_step("select r1", OP_WRITE, 32'hc, 1, 0);
      add_step("debug r1", OP_READ, 32'hc, 0, {1'b0, pool[0]});
      add_step("select r2", OP_WRITE, 32'hc, 2, 0);
      add_step("debug r2", OP_READ, 32'hc, 0, {1'b0, pool[1]});
      add_step("select r3", OP_WRITE, 32'hc, 3, 0);
      add_step("debug r3", OP_READ, 32'hc, 0, {1'b0, pool[3]});
      add_step("select r6", OP_WRITE, 32'hc, 6, 0);
      add_step("debug r6", OP_READ, 32'hc, 0, {1'b0, pool[4]});
      // Flushes leave the counter alone
      add_step("commit count after flushes", OP_READ, 32'h4, 0, 33'h5);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic report_mismatch(input string name, input logic [32:0] expected,
                                  input logic [32:0] actual);
      errors++;
      $display("[FAIL] %s: expected %h, got %h", name, expected, actual);
   endtask

   task automatic run_dispatch(input step_t s, input string name);
      logic [32:0] got;
      dispatch_valid = 1'b1;
      dispatch.dest  = s.arg[`FCPU_REG_ADDR_W-1:0];
      dispatch.src_a = '0;
      dispatch.src_b = '0;
      #8;
      got = {dispatch_ready, 29'd0, dispatch_tag};
      if (got !== s.expected) report_mismatch(name, s.expected, got);
      next_cycle();
      dispatch_valid = 1'b0;
   endtask

   // Each port reads the register in turn while the other port reads r0
   task automatic run_check(input step_t s, input string name);
      logic [`FCPU_REG_ADDR_W-1:0] idx;
      logic [32:0]                 r0_value;
      idx      = s.arg[`FCPU_REG_ADDR_W-1:0];
      r0_value = ready_operand(0);
      dispatch.src_a = idx;
      dispatch.src_b = '0;
      #8;
      if (src_a !== s.expected) report_mismatch({name, " src_a"}, s.expected, src_a);
      if (src_b !== r0_value) report_mismatch({name, " src_b r0"}, r0_value, src_b);
      next_cycle();
      dispatch.src_a = '0;
      dispatch.src_b = idx;
      #8;
      if (src_b !== s.expected) report_mismatch({name, " src_b"}, s.expected, src_b);
      if (src_a !== r0_value) report_mismatch({name, " src_a r0"}, r0_value, src_a);
      next_cycle();
   endtask

   task automatic axi_write(input step_t s, input string name);
      int waited;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      awaddr  = s.arg[3:0];
      wdata   = s.data;
      wstrb   = 4'hf;
      waited  = 0;
      #8;
      while (!(awready && wready) && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #8;
         waited++;
      end
      if (!(awready && wready)) begin
         timeouts++;
         $display("%s: the write address and data were never accepted", name);
      end
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      waited  = 0;
      #8;
      while (!bvalid && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #8;
         waited++;
      end
      if (!bvalid) begin
         timeouts++;
         $display("%s: no write response arrived", name);
      end else if (bresp !== 2'b00) begin
         report_mismatch({name, " bresp"}, 33'd0, {31'd0, bresp});
      end
      next_cycle();
   endtask

   task automatic axi_read(input step_t s, input string name);
      int waited;
      arvalid = 1'b1;
      araddr  = s.arg[3:0];
      waited  = 0;
      #8;
      while (!arready && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #8;
         waited++;
      end
      if (!arready) begin
         timeouts++;
         $display("%s: the read address was never accepted", name);
      end
      next_cycle();
      arvalid = 1'b0;
      waited  = 0;
      #8;
      while (!rvalid && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #8;
         waited++;
      end
      if (!rvalid) begin
         timeouts++;
         $display("%s: no read data arrived", name);
      end else begin
         if (rdata !== s.expected[31:0]) begin
            report_mismatch(name, s.expected, {1'b0, rdata});
         end
         if (rresp !== 2'b00) begin
            report_mismatch({name, " rresp"}, 33'd0, {31'd0, rresp});
         end
      end
      next_cycle();
   endtask

   initial begin
      void'($urandom(32'h5e85477b));
      for (int i = 0; i < 8; i++) begin
         pool[i] = $urandom();
      end
      clk            = 1'b0;
      nrst           = 1'b1;
      branch_miss    = 1'b0;
      dispatch_valid = 1'b0;
      dispatch       = '0;
      wb             = '0;
      awvalid        = 1'b0;
      awaddr         = '0;
      wvalid         = 1'b0;
      wdata          = '0;
      wstrb          = '0;
      bready         = 1'b1;
      arvalid        = 1'b0;
      araddr         = '0;
      rready         = 1'b1;
      errors         = 0;
      timeouts       = 0;
      build_table();

      repeat (16) @(posedge clk);
      #2;
      nrst = 1'b0;

      for (int i = 0; i < steps.size(); i++) begin
         case (steps[i].op)
            OP_DISPATCH: run_dispatch(steps[i], step_names[i]);
            OP_WB: begin
               wb.valid = 1'b1;
               wb.tag   = steps[i].arg[`FCPU_TAG_W-1:0];
               wb.data  = steps[i].data;
               next_cycle();
               wb.valid = 1'b0;
            end
            OP_MISS: begin
               branch_miss = 1'b1;
               next_cycle();
               branch_miss = 1'b0;
            end
            OP_WRITE: axi_write(steps[i], step_names[i]);
            OP_READ:  axi_read(steps[i], step_names[i]);
            OP_CHECK: run_check(steps[i], step_names[i]);
            default:  next_cycle();
         endcase
      end

      $display("Ran %0d steps: %0d value errors, %0d timeouts", steps.size(), errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== logic/rename_core.sv ====
`include "fcpu_defines.svh"

module rename_core (
   input  logic                   clk,
   input  logic                   nrst,
   input  logic                   branch_miss,
   input  logic                   dispatch_valid,
   output logic                   dispatch_ready,
   input  fcpu_pkg::dispatch_t    dispatch,
   output logic [`FCPU_TAG_W-1:0] dispatch_tag,
   output fcpu_pkg::operand_t     src_a,
   output fcpu_pkg::operand_t     src_b,
   input  fcpu_pkg::writeback_t   wb,
   input  logic                   awvalid,
   output logic                   awready,
   input  logic [3:0]             awaddr,
   input  logic                   wvalid,
   output logic                   wready,
   input  logic [31:0]            wdata,
   input  logic [3:0]             wstrb,
   output logic                   bvalid,
   input  logic                   bready,
   output logic [1:0]             bresp,
   input  logic                   arvalid,
   output logic                   arready,
   input  logic [3:0]             araddr,
   output logic                   rvalid,
   input  logic                   rready,
   output logic [31:0]            rdata,
   output logic [1:0]             rresp
);

   logic                        flush;
   logic                        flush_req;
   logic                        rename_valid;
   logic [3:0]                  occupancy;
   fcpu_pkg::commit_t           commit;
   logic [`FCPU_REG_ADDR_W-1:0] debug_addr;
   logic [`FCPU_DATA_W-1:0]     debug_data;

   assign flush        = branch_miss || flush_req;
   assign rename_valid = dispatch_valid && dispatch_ready;

   register_file register_file_i (
      .clk, .nrst, .flush, .rename_valid,
      .rename     (dispatch),
      .rename_tag (dispatch_tag),
      .commit, .debug_addr, .src_a, .src_b, .debug_data
   );

   reorder_buffer reorder_buffer_i (
      .clk, .nrst, .flush,
      .alloc_valid (rename_valid),
      .alloc_dest  (dispatch.dest),
      .wb,
      .alloc_ready (dispatch_ready),
      .alloc_tag   (dispatch_tag),
      .commit, .occupancy
   );

   rename_csr rename_csr_i (
      .clk, .nrst,
      .awvalid, .awready, .awaddr, .wvalid, .wready, .wdata, .wstrb,
      .bvalid, .bready, .bresp, .arvalid, .arready, .araddr,
      .rvalid, .rready, .rdata, .rresp,
      .occupancy,
      .commit_valid (commit.valid),
      .debug_data, .flush_req, .debug_addr
   );

endmodule

// ==== logic/rename_csr.sv ====
`include "fcpu_defines.svh"

module rename_csr (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        awvalid,
   output logic                        awready,
   input  logic [3:0]                  awaddr,
   input  logic                        wvalid,
   output logic                        wready,
   input  logic [31:0]                 wdata,
   input  logic [3:0]                  wstrb,
   output logic                        bvalid,
   input  logic                        bready,
   output logic [1:0]                  bresp,
   input  logic                        arvalid,
   output logic                        arready,
   input  logic [3:0]                  araddr,
   output logic                        rvalid,
   input  logic                        rready,
   output logic [31:0]                 rdata,
   output logic [1:0]                  rresp,
   input  logic [3:0]                  occupancy,
   input  logic                        commit_valid,
   input  logic [`FCPU_DATA_W-1:0]     debug_data,
   output logic                        flush_req,
   output logic [`FCPU_REG_ADDR_W-1:0] debug_addr
);

   localparam logic [1:0] ADDR_STATUS = 2'd0;
   localparam logic [1:0] ADDR_COUNT  = 2'd1;
   localparam logic [1:0] ADDR_CTRL   = 2'd2;
   localparam logic [1:0] ADDR_DEBUG  = 2'd3;

   logic        wr_accept;
   logic        rd_accept;
   logic        full;
   logic [31:0] commit_count;
   logic [31:0] read_word;

   // One outstanding response per channel
   assign awready = !bvalid;
   assign wready  = !bvalid;
   assign arready = !rvalid;
   assign bresp   = 2'b00;
   assign rresp   = 2'b00;

   assign wr_accept = awvalid && wvalid && awready && wready;
   assign rd_accept = arvalid && arready;

   assign full = (occupancy == 4'(`FCPU_ROB_DEPTH));

   always_comb begin
      case (araddr[3:2])
         ADDR_STATUS: read_word = {27'd0, full, occupancy};
         ADDR_COUNT:  read_word = commit_count;
         ADDR_DEBUG:  read_word = debug_data;
         default:     read_word = 32'd0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         bvalid       <= 1'b0;
         rvalid       <= 1'b0;
         flush_req    <= 1'b0;
         debug_addr   <= '0;
         commit_count <= '0;
      end else begin
         flush_req <= wr_accept && (awaddr[3:2] == ADDR_CTRL) && wstrb[0] && wdata[0];

         if (wr_accept && (awaddr[3:2] == ADDR_DEBUG) && wstrb[0]) begin
            debug_addr <= wdata[`FCPU_REG_ADDR_W-1:0];
         end

         if (wr_accept) begin
            bvalid <= 1'b1;
         end else if (bready) begin
            bvalid <= 1'b0;
         end

         if (rd_accept) begin
            rvalid <= 1'b1;
         end else if (rready) begin
            rvalid <= 1'b0;
         end

         if (commit_valid) begin
            commit_count <= commit_count + 32'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_accept) begin
         rdata <= read_word;
      end
   end

   write_resp_follows_write: assert property (
      @(posedge clk) disable iff (nrst)
      $rose(bvalid) |-> $past(wr_accept)
   );

endmodule

// ==== logic/reorder_buffer.sv ====
`include "fcpu_defines.svh"

module reorder_buffer (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        flush,
   input  logic                        alloc_valid,
   input  logic [`FCPU_REG_ADDR_W-1:0] alloc_dest,
   input  fcpu_pkg::writeback_t        wb,
   output logic                        alloc_ready,
   output logic [`FCPU_TAG_W-1:0]      alloc_tag,
   output fcpu_pkg::commit_t           commit,
   output logic [3:0]                  occupancy
);

   localparam int DEPTH = `FCPU_ROB_DEPTH;

   logic [`FCPU_TAG_W-1:0] head;
   logic [`FCPU_TAG_W-1:0] tail;
   logic [3:0]             count;

   logic [DEPTH-1:0][`FCPU_REG_ADDR_W-1:0] dest_q;
   logic [DEPTH-1:0][`FCPU_DATA_W-1:0]     data_q;
   logic [DEPTH-1:0]                       done;

   logic                   do_alloc;
   logic                   do_commit;
   logic [`FCPU_TAG_W-1:0] wb_offset;

   assign alloc_ready = (count != 4'(DEPTH));
   assign alloc_tag   = tail;
   assign occupancy   = count;

   // A flush drops any allocation in the same cycle
   assign do_alloc = alloc_valid && alloc_ready && !flush;

   // Head retires as soon as its result is in; nothing retires across a flush
   assign commit.valid = (count != 4'd0) && done[head] && !flush;
   assign commit.tag   = head;
   assign commit.dest  = dest_q[head];
   assign commit.data  = data_q[head];
   assign do_commit    = commit.valid;

   // Distance from the head, used to tell whether a tag is in flight
   assign wb_offset = wb.tag - head;

   always_ff @(posedge clk) begin
      if (nrst) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         done  <= '0;
      end else if (flush) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
         done  <= '0;
      end else begin
         if (do_alloc) begin
            tail       <= tail + 1'b1;
            done[tail] <= 1'b0;
         end
         if (wb.valid) begin
            done[wb.tag] <= 1'b1;
         end
         if (do_commit) begin
            head <= head + 1'b1;
         end
         case ({do_alloc, do_commit})
            2'b10:   count <= count + 4'd1;
            2'b01:   count <= count - 4'd1;
            default: count <= count;
         endcase
      end
   end

   // Entry payload
   always_ff @(posedge clk) begin
      if (do_alloc) begin
         dest_q[tail] <= alloc_dest;
      end
      if (wb.valid) begin
         data_q[wb.tag] <= wb.data;
      end
   end

   // A full buffer hands out no tag, so the tail stays put until an entry retires
   no_alloc_when_full: assert property (
      @(posedge clk) disable iff (nrst)
      (count == 4'(DEPTH)) && !flush |=> (tail == $past(tail))
   );

   // Execution only completes tags that were handed out and are still waiting
   wb_to_pending_entry: assert property (
      @(posedge clk) disable iff (nrst || flush)
      wb.valid |-> ({1'b0, wb_offset} < count) && !done[wb.tag]
   );

endmodule

// ==== logic/register_file.sv ====
`include "fcpu_defines.svh"

module register_file (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        flush,
   input  logic                        rename_valid,
   input  fcpu_pkg::dispatch_t         rename,
   input  logic [`FCPU_TAG_W-1:0]      rename_tag,
   input  fcpu_pkg::commit_t           commit,
   input  logic [`FCPU_REG_ADDR_W-1:0] debug_addr,
   output fcpu_pkg::operand_t          src_a,
   output fcpu_pkg::operand_t          src_b,
   output logic [`FCPU_DATA_W-1:0]     debug_data
);

   localparam int NUM_REGS = 2 ** `FCPU_REG_ADDR_W;

   logic [NUM_REGS-1:0][`FCPU_DATA_W-1:0] values;
   logic [NUM_REGS-1:0][`FCPU_TAG_W-1:0]  tags;
   logic [NUM_REGS-1:0]                   ready;

   // Pick the union view that matches the ready bit
   function automatic fcpu_pkg::operand_t build_operand(
      input logic                    rdy,
      input logic [`FCPU_TAG_W-1:0]  tag,
      input logic [`FCPU_DATA_W-1:0] value
   );
      fcpu_pkg::operand_t op;
      op.ready = rdy;
      if (rdy) begin
         op.value.data = value;
      end else begin
         op.value.tag_view.pad = '0;
         op.value.tag_view.tag = tag;
      end
      return op;
   endfunction

   // Reads see the state before the edge, so a source equal to dest gets the old mapping
   assign src_a = build_operand(ready[rename.src_a], tags[rename.src_a],
                                values[rename.src_a]);
   assign src_b = build_operand(ready[rename.src_b], tags[rename.src_b],
                                values[rename.src_b]);

   assign debug_data = values[debug_addr];

   always_ff @(posedge clk) begin
      if (nrst) begin
         values <= '0;
         tags   <= '0;
         ready  <= '1;
      end else begin
         if (commit.valid) begin
            values[commit.dest] <= commit.data;
            // An older producer must not release a register that was renamed again
            if (tags[commit.dest] == commit.tag) begin
               ready[commit.dest] <= 1'b1;
            end
         end

         // Later assignments win, so a rename beats a commit to the same register
         if (flush) begin
            ready <= '1;
         end else if (rename_valid) begin
            tags[rename.dest]  <= rename_tag;
            ready[rename.dest] <= 1'b0;
         end
      end
   end

   // The reorder buffer only retires into a pending register or a superseded rename
   commit_target_pending: assert property (
      @(posedge clk) disable iff (nrst)
      commit.valid |-> !(ready[commit.dest] && (tags[commit.dest] != commit.tag))
   );

endmodule

// ==== logic/fcpu_pkg.sv ====
`include "fcpu_defines.svh"

package fcpu_pkg;

   // One operand word. It holds a value when ready, or the tag of the producer in flight
   typedef union packed {
      logic [`FCPU_DATA_W-1:0] data;
      struct packed {
         logic [`FCPU_DATA_W-`FCPU_TAG_W-1:0] pad;
         logic [`FCPU_TAG_W-1:0]              tag;
      } tag_view;
   } operand_u;

   typedef struct packed {
      logic     ready;
      operand_u value;
   } operand_t;

   // Register indices of one instruction at dispatch
   typedef struct packed {
      logic [`FCPU_REG_ADDR_W-1:0] dest;
      logic [`FCPU_REG_ADDR_W-1:0] src_a;
      logic [`FCPU_REG_ADDR_W-1:0] src_b;
   } dispatch_t;

   // Result returned by the execution side, in any order
   typedef struct packed {
      logic                    valid;
      logic [`FCPU_TAG_W-1:0]  tag;
      logic [`FCPU_DATA_W-1:0] data;
   } writeback_t;

   // In-order retirement from the reorder buffer into the register file
   typedef struct packed {
      logic                        valid;
      logic [`FCPU_TAG_W-1:0]      tag;
      logic [`FCPU_REG_ADDR_W-1:0] dest;
      logic [`FCPU_DATA_W-1:0]     data;
   } commit_t;

endpackage

// ==== logic/fcpu_defines.svh ====
`ifndef FCPU_DEFINES_SVH
`define FCPU_DEFINES_SVH

// Width of register values and operand words
`define FCPU_DATA_W 32

// Index width of the architectural register file
`define FCPU_REG_ADDR_W 5

// Width of a reorder-buffer tag, which is also the rename tag
`define FCPU_TAG_W 3

// Number of reorder-buffer entries, one per tag value
`define FCPU_ROB_DEPTH 8

`endif
